/* common/fads_consts.svh */
// FADS register map, reset defaults and classification bit positions
// shared by the register block and the droplet evaluator
`ifndef FADS_CONSTS_SVH
`define FADS_CONSTS_SVH

// decoded part of the bus address
`define FADS_ADDR_BITS          20

// configuration registers
`define FADS_ADDR_MIN_INT       20'h00000
`define FADS_ADDR_LOW_INT       20'h00004
`define FADS_ADDR_HIGH_INT      20'h00008
`define FADS_ADDR_MIN_WIDTH     20'h00010
`define FADS_ADDR_LOW_WIDTH     20'h00014
`define FADS_ADDR_HIGH_WIDTH    20'h00018
`define FADS_ADDR_SORT_DELAY    20'h00024
`define FADS_ADDR_SORT_DUR      20'h00028

// event counters
`define FADS_ADDR_LOW_INT_CNT   20'h00100
`define FADS_ADDR_HIGH_INT_CNT  20'h00104
`define FADS_ADDR_SHORT_CNT     20'h00108
`define FADS_ADDR_LONG_CNT      20'h0010C
`define FADS_ADDR_POS_CNT       20'h00110
`define FADS_ADDR_NEG_CNT       20'h00114

// last droplet record
`define FADS_ADDR_DROPLET_ID    20'h00200
`define FADS_ADDR_LAST_PEAK     20'h00204
`define FADS_ADDR_LAST_WIDTH    20'h00208
`define FADS_ADDR_CLASS         20'h0020C

// reset defaults, intensities in ADC counts
`define FADS_DEF_MIN_INT        (-14'sd250)
`define FADS_DEF_LOW_INT        (-14'sd240)
`define FADS_DEF_HIGH_INT       (14'sd500)
`define FADS_DEF_MIN_WIDTH      32'd1
`define FADS_DEF_LOW_WIDTH      32'd4
`define FADS_DEF_HIGH_WIDTH     32'd1000
// 250 us and 1 ms at 125 MHz
`define FADS_DEF_SORT_DELAY     32'd31250
`define FADS_DEF_SORT_DUR       32'd125000

// classification byte, bit 6 stays zero
`define CLS_LOW_INT             0
`define CLS_POS_INT             1
`define CLS_HIGH_INT            2
`define CLS_SHORT               3
`define CLS_POS_WIDTH           4
`define CLS_LONG                5
`define CLS_POS_DROP            7

`endif

/* common/fads_pkg.sv */
// FADS shared types
// samples, widths, counters, window classes, droplet record, config and status
package fads_pkg;

    // signed fast ADC sample
    typedef logic signed [13:0] adc_sample_t;

    // droplet width in clock cycles
    typedef logic [31:0] width_t;

    typedef logic [31:0] count_t;

    // position of a value relative to min / low / high thresholds
    typedef enum logic [1:0] {
        WIN_BELOW,
        WIN_LOW,
        WIN_PASS,
        WIN_HIGH
    } win_class_t;

    typedef struct packed {
        adc_sample_t peak;
        width_t      width;
    } droplet_t;

    // host configuration
    typedef struct packed {
        adc_sample_t min_int;
        adc_sample_t low_int;
        adc_sample_t high_int;
        width_t      min_width;
        width_t      low_width;
        width_t      high_width;
        count_t      sort_delay;
        count_t      sort_duration;
    } fads_cfg_t;

    // counters and last droplet, read back by the host
    typedef struct packed {
        count_t      low_int_cnt;
        count_t      high_int_cnt;
        count_t      short_cnt;
        count_t      long_cnt;
        count_t      positive_cnt;
        count_t      negative_cnt;
        count_t      droplet_id;
        droplet_t    last;
        logic [7:0]  classification;
    } fads_stat_t;

endpackage

/* src/droplet/window_classify.sv */
// three-threshold window classifier
// same compare chain for signed peak and unsigned width via a type parameter
module window_classify #(
    parameter type value_t = logic [31:0]
) (
    input  value_t               value_i,
    input  value_t               min_i,
    input  value_t               low_i,
    input  value_t               high_i,
    output fads_pkg::win_class_t class_o
);
    import fads_pkg::*;

    // compares follow the signedness of value_t
    always_comb begin
        if (value_i < min_i) begin
            class_o = WIN_BELOW;
        end else if (value_i < low_i) begin
            class_o = WIN_LOW;
        end else if (value_i < high_i) begin
            class_o = WIN_PASS;
        end else begin
            class_o = WIN_HIGH;
        end
    end

endmodule

/* src/droplet/droplet_measure.sv */
// droplet detector
// tracks peak and width while the signal stays at or above min intensity,
// emits the record one cycle after the first sample below it
module droplet_measure (
    input  logic                  adc_clk_i,
    input  logic                  fads_reset,
    input  fads_pkg::adc_sample_t adc_a_i,
    input  fads_pkg::fads_cfg_t   cfg_i,
    output fads_pkg::droplet_t    drop_o,
    output logic                  drop_valid_o
);
    import fads_pkg::*;

    typedef enum logic {S_IDLE, S_DROP} state_t;

    state_t      state;
    adc_sample_t min_int;
    adc_sample_t peak;
    width_t      width;
    logic        above;

    // local copy keeps the compare signed
    assign min_int = cfg_i.min_int;
    assign above   = (adc_a_i >= min_int);

    // control
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state        <= S_IDLE;
            drop_valid_o <= 1'b0;
        end else begin
            drop_valid_o <= 1'b0;
            case (state)
                S_IDLE: if (above) state <= S_DROP;
                S_DROP: begin
                    if (!above) begin
                        state        <= S_IDLE;
                        drop_valid_o <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // running peak and width, first sample seeds both
    always_ff @(posedge adc_clk_i) begin
        if (state == S_IDLE && above) begin
            peak  <= adc_a_i;
            width <= 32'd1;
        end else if (state == S_DROP && above) begin
            width <= width + 32'd1;
            if (adc_a_i > peak) peak <= adc_a_i;
        end
        // finished record
        if (state == S_DROP && !above) begin
            drop_o.peak  <= peak;
            drop_o.width <= width;
        end
    end

    // at least one idle cycle between records
    single_valid: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        drop_valid_o |=> !drop_valid_o);

endmodule

/* src/droplet/droplet_eval.sv */
// droplet evaluator
// classifies each finished droplet, keeps counters and the last record,
// requests a sort pulse for positive droplets
`include "fads_consts.svh"

module droplet_eval (
    input  logic                 adc_clk_i,
    input  logic                 fads_reset,
    input  fads_pkg::droplet_t   drop_i,
    input  logic                 drop_valid_i,
    input  fads_pkg::fads_cfg_t  cfg_i,
    input  logic                 sort_ack_i,
    output logic                 sort_req_o,
    output fads_pkg::fads_stat_t stat_o
);
    import fads_pkg::*;

    win_class_t int_cls;
    win_class_t width_cls;
    logic [7:0] cls_byte;
    logic       counted;
    logic       positive;

    window_classify #(.value_t(adc_sample_t)) int_cls_i (
        .value_i (drop_i.peak),
        .min_i   (cfg_i.min_int),
        .low_i   (cfg_i.low_int),
        .high_i  (cfg_i.high_int),
        .class_o (int_cls)
    );

    window_classify #(.value_t(width_t)) width_cls_i (
        .value_i (drop_i.width),
        .min_i   (cfg_i.min_width),
        .low_i   (cfg_i.low_width),
        .high_i  (cfg_i.high_width),
        .class_o (width_cls)
    );

    // too narrow means noise, not a droplet
    assign counted  = drop_valid_i && (width_cls != WIN_BELOW);
    assign positive = (int_cls == WIN_PASS) && (width_cls == WIN_PASS);

    always_comb begin
        cls_byte                 = 8'd0;
        cls_byte[`CLS_LOW_INT]   = (int_cls == WIN_LOW);
        cls_byte[`CLS_POS_INT]   = (int_cls == WIN_PASS);
        cls_byte[`CLS_HIGH_INT]  = (int_cls == WIN_HIGH);
        cls_byte[`CLS_SHORT]     = (width_cls == WIN_LOW);
        cls_byte[`CLS_POS_WIDTH] = (width_cls == WIN_PASS);
        cls_byte[`CLS_LONG]      = (width_cls == WIN_HIGH);
        cls_byte[`CLS_POS_DROP]  = positive;
    end

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            stat_o     <= '0;
            sort_req_o <= 1'b0;
        end else begin
            // second phase of the handshake
            if (sort_ack_i) sort_req_o <= 1'b0;
            if (counted) begin
                stat_o.droplet_id     <= stat_o.droplet_id + 32'd1;
                stat_o.last           <= drop_i;
                stat_o.classification <= cls_byte;
                if (int_cls == WIN_LOW)    stat_o.low_int_cnt  <= stat_o.low_int_cnt + 32'd1;
                if (int_cls == WIN_HIGH)   stat_o.high_int_cnt <= stat_o.high_int_cnt + 32'd1;
                if (width_cls == WIN_LOW)  stat_o.short_cnt    <= stat_o.short_cnt + 32'd1;
                if (width_cls == WIN_HIGH) stat_o.long_cnt     <= stat_o.long_cnt + 32'd1;
                if (positive) begin
                    stat_o.positive_cnt <= stat_o.positive_cnt + 32'd1;
                    // timer busy or request pending, droplet goes unsorted
                    if (!sort_req_o && !sort_ack_i) sort_req_o <= 1'b1;
                end else begin
                    stat_o.negative_cnt <= stat_o.negative_cnt + 32'd1;
                end
            end
        end
    end

    // request held until the timer answers
    req_held: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        (sort_req_o && !sort_ack_i) |=> sort_req_o);

endmodule

/* src/sort_timer.sv */
// sort trigger timer
// takes a request while idle, waits sort_delay cycles,
// then drives the trigger for sort_duration cycles
module sort_timer (
    input  logic                adc_clk_i,
    input  logic                fads_reset,
    input  fads_pkg::fads_cfg_t cfg_i,
    input  logic                sort_req_i,
    output logic                sort_ack_o,
    output logic                sort_trig_o
);
    import fads_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_DELAY, S_TRIG} state_t;

    state_t state;
    // remaining cycles of the current phase, zero acts as one
    count_t cnt;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state       <= S_IDLE;
            cnt         <= '0;
            sort_ack_o  <= 1'b0;
            sort_trig_o <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // ack stays up through the pulse, released once req is gone
                    if (sort_ack_o) begin
                        if (!sort_req_i) sort_ack_o <= 1'b0;
                    end else if (sort_req_i) begin
                        sort_ack_o <= 1'b1;
                        cnt        <= cfg_i.sort_delay;
                        state      <= S_DELAY;
                    end
                end
                S_DELAY: begin
                    if (cnt <= 32'd1) begin
                        cnt         <= cfg_i.sort_duration;
                        sort_trig_o <= 1'b1;
                        state       <= S_TRIG;
                    end else begin
                        cnt <= cnt - 32'd1;
                    end
                end
                S_TRIG: begin
                    if (cnt <= 32'd1) begin
                        sort_trig_o <= 1'b0;
                        state       <= S_IDLE;
                    end else begin
                        cnt <= cnt - 32'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // no stray pulse outside a sort cycle
    trig_idle_low: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        (state == S_IDLE) |-> !sort_trig_o);

endmodule

/* src/fads_regs.sv */
// FADS register block
// decodes host writes into the configuration, muxes config and status
// into registered read data, acks one cycle after each enable
`include "fads_consts.svh"

module fads_regs (
    input  logic                 adc_clk_i,
    input  logic                 fads_reset,
    input  logic [31:0]          sys_addr_i,
    input  logic [31:0]          sys_wdata_i,
    input  logic                 sys_wen_i,
    input  logic                 sys_ren_i,
    output logic [31:0]          sys_rdata_o,
    output logic                 sys_ack_o,
    input  fads_pkg::fads_stat_t stat_i,
    output fads_pkg::fads_cfg_t  cfg_o
);
    import fads_pkg::*;

    localparam int SW = $bits(adc_sample_t);

    logic [`FADS_ADDR_BITS-1:0] addr;
    logic                       sys_en;
    logic [31:0]                rd_mux;

    // intensities go out sign-extended
    function automatic logic [31:0] sext(input adc_sample_t v);
        return {{(32 - SW){v[SW-1]}}, v};
    endfunction

    assign addr   = sys_addr_i[`FADS_ADDR_BITS-1:0];
    assign sys_en = sys_wen_i | sys_ren_i;

    // config writes
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            cfg_o.min_int       <= `FADS_DEF_MIN_INT;
            cfg_o.low_int       <= `FADS_DEF_LOW_INT;
            cfg_o.high_int      <= `FADS_DEF_HIGH_INT;
            cfg_o.min_width     <= `FADS_DEF_MIN_WIDTH;
            cfg_o.low_width     <= `FADS_DEF_LOW_WIDTH;
            cfg_o.high_width    <= `FADS_DEF_HIGH_WIDTH;
            cfg_o.sort_delay    <= `FADS_DEF_SORT_DELAY;
            cfg_o.sort_duration <= `FADS_DEF_SORT_DUR;
        end else if (sys_wen_i) begin
            case (addr)
                `FADS_ADDR_MIN_INT:    cfg_o.min_int       <= sys_wdata_i[SW-1:0];
                `FADS_ADDR_LOW_INT:    cfg_o.low_int       <= sys_wdata_i[SW-1:0];
                `FADS_ADDR_HIGH_INT:   cfg_o.high_int      <= sys_wdata_i[SW-1:0];
                `FADS_ADDR_MIN_WIDTH:  cfg_o.min_width     <= sys_wdata_i;
                `FADS_ADDR_LOW_WIDTH:  cfg_o.low_width     <= sys_wdata_i;
                `FADS_ADDR_HIGH_WIDTH: cfg_o.high_width    <= sys_wdata_i;
                `FADS_ADDR_SORT_DELAY: cfg_o.sort_delay    <= sys_wdata_i;
                `FADS_ADDR_SORT_DUR:   cfg_o.sort_duration <= sys_wdata_i;
                default: ;
            endcase
        end
    end

    // read mux, unmapped addresses give 0
    always_comb begin
        case (addr)
            `FADS_ADDR_MIN_INT:      rd_mux = sext(cfg_o.min_int);
            `FADS_ADDR_LOW_INT:      rd_mux = sext(cfg_o.low_int);
            `FADS_ADDR_HIGH_INT:     rd_mux = sext(cfg_o.high_int);
            `FADS_ADDR_MIN_WIDTH:    rd_mux = cfg_o.min_width;
            `FADS_ADDR_LOW_WIDTH:    rd_mux = cfg_o.low_width;
            `FADS_ADDR_HIGH_WIDTH:   rd_mux = cfg_o.high_width;
            `FADS_ADDR_SORT_DELAY:   rd_mux = cfg_o.sort_delay;
            `FADS_ADDR_SORT_DUR:     rd_mux = cfg_o.sort_duration;
            `FADS_ADDR_LOW_INT_CNT:  rd_mux = stat_i.low_int_cnt;
            `FADS_ADDR_HIGH_INT_CNT: rd_mux = stat_i.high_int_cnt;
            `FADS_ADDR_SHORT_CNT:    rd_mux = stat_i.short_cnt;
            `FADS_ADDR_LONG_CNT:     rd_mux = stat_i.long_cnt;
            `FADS_ADDR_POS_CNT:      rd_mux = stat_i.positive_cnt;
            `FADS_ADDR_NEG_CNT:      rd_mux = stat_i.negative_cnt;
            `FADS_ADDR_DROPLET_ID:   rd_mux = stat_i.droplet_id;
            `FADS_ADDR_LAST_PEAK:    rd_mux = sext(stat_i.last.peak);
            `FADS_ADDR_LAST_WIDTH:   rd_mux = stat_i.last.width;
            `FADS_ADDR_CLASS:        rd_mux = {24'd0, stat_i.classification};
            default:                 rd_mux = 32'd0;
        endcase
    end

    // data captured on the enable cycle
    always_ff @(posedge adc_clk_i) begin
        if (sys_en) begin
            sys_rdata_o <= rd_mux;
        end
    end

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            sys_ack_o <= 1'b0;
        end else begin
            sys_ack_o <= sys_en;
        end
    end

    // every ack answers an access of the cycle before
    ack_after_en: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

endmodule

/* src/fads_top.sv */
// FADS top level
// one detector channel: measure droplets, classify them, fire the sort trigger
module fads_top (
    input  logic                  adc_clk_i,
    input  logic                  fads_reset,
    input  fads_pkg::adc_sample_t adc_a_i,
    input  logic [31:0]           sys_addr_i,
    input  logic [31:0]           sys_wdata_i,
    input  logic                  sys_wen_i,
    input  logic                  sys_ren_i,
    output logic [31:0]           sys_rdata_o,
    output logic                  sys_ack_o,
    output logic                  sort_trig_o
);
    import fads_pkg::*;

    fads_cfg_t  cfg;
    fads_stat_t stat;
    droplet_t   drop;
    logic       drop_valid;
    // four-phase link between evaluator and timer
    logic       sort_req;
    logic       sort_ack;

    fads_regs fads_regs_i (
        .adc_clk_i   (adc_clk_i),
        .fads_reset  (fads_reset),
        .sys_addr_i  (sys_addr_i),
        .sys_wdata_i (sys_wdata_i),
        .sys_wen_i   (sys_wen_i),
        .sys_ren_i   (sys_ren_i),
        .sys_rdata_o (sys_rdata_o),
        .sys_ack_o   (sys_ack_o),
        .stat_i      (stat),
        .cfg_o       (cfg)
    );

    droplet_measure droplet_measure_i (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .adc_a_i      (adc_a_i),
        .cfg_i        (cfg),
        .drop_o       (drop),
        .drop_valid_o (drop_valid)
    );

    droplet_eval droplet_eval_i (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .drop_i       (drop),
        .drop_valid_i (drop_valid),
        .cfg_i        (cfg),
        .sort_ack_i   (sort_ack),
        .sort_req_o   (sort_req),
        .stat_o       (stat)
    );

    sort_timer sort_timer_i (
        .adc_clk_i   (adc_clk_i),
        .fads_reset  (fads_reset),
        .cfg_i       (cfg),
        .sort_req_i  (sort_req),
        .sort_ack_o  (sort_ack),
        .sort_trig_o (sort_trig_o)
    );

endmodule

/* testbench/tb_fads.sv */
// FADS testbench
// directed tests over the register bus and the ADC input:
// defaults, classification, counters, sort trigger timing and busy handling
`include "fads_consts.svh"

module tb_fads;
    import fads_pkg::*;

    localparam int          ACK_TIMEOUT  = 20;
    localparam int          TRIG_TIMEOUT = 200;
    localparam adc_sample_t BASELINE     = -14'sd1000;

    logic        adc_clk_i;
    logic        fads_reset;
    adc_sample_t adc_a_i;
    logic [31:0] sys_addr_i;
    logic [31:0] sys_wdata_i;
    logic        sys_wen_i;
    logic        sys_ren_i;
    logic [31:0] sys_rdata_o;
    logic        sys_ack_o;
    logic        sort_trig_o;

    integer      seed = 38;
    // counters as last read, index order follows counter_addr
    count_t      snap[7];

    fads_top fads_top_i (
        .adc_clk_i   (adc_clk_i),
        .fads_reset  (fads_reset),
        .adc_a_i     (adc_a_i),
        .sys_addr_i  (sys_addr_i),
        .sys_wdata_i (sys_wdata_i),
        .sys_wen_i   (sys_wen_i),
        .sys_ren_i   (sys_ren_i),
        .sys_rdata_o (sys_rdata_o),
        .sys_ack_o   (sys_ack_o),
        .sort_trig_o (sort_trig_o)
    );

    initial begin
        adc_clk_i = 1'b0;
        forever #4 adc_clk_i = ~adc_clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    // compare tasks, one per result type
    task automatic check_count(input count_t got, input count_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_sample(input adc_sample_t got, input adc_sample_t exp,
                                input string what);
        if (got !== exp)
            abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_width(input width_t got, input width_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_class(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAIL at %0t: class byte is %02h, expected %02h",
                                $time, got, exp));
    endtask

    // one access: enable for a single cycle, then wait for the ack
    task automatic bus_access(input logic [`FADS_ADDR_BITS-1:0] addr, input logic [31:0] wdata,
                              input logic write, output logic [31:0] rdata);
        int waited;
        @(negedge adc_clk_i);
        sys_addr_i  = {12'd0, addr};
        sys_wdata_i = wdata;
        sys_wen_i   = write;
        sys_ren_i   = !write;
        @(negedge adc_clk_i);
        sys_wen_i = 1'b0;
        sys_ren_i = 1'b0;
        waited    = 0;
        while (!sys_ack_o) begin
            if (waited == ACK_TIMEOUT) abort_run("bus ack did not arrive in time");
            @(negedge adc_clk_i);
            waited++;
        end
        rdata = sys_rdata_o;
    endtask

    task automatic bus_write(input logic [`FADS_ADDR_BITS-1:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(addr, wdata, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [`FADS_ADDR_BITS-1:0] addr, output logic [31:0] rdata);
        bus_access(addr, 32'd0, 1'b0, rdata);
    endtask

    // intensity readback, upper bits must repeat the sign
    task automatic read_sample(input logic [`FADS_ADDR_BITS-1:0] addr, output adc_sample_t v);
        logic [31:0] d;
        bus_read(addr, d);
        if (d[31:14] !== {18{d[13]}})
            abort_run($sformatf("intensity at 0x%03h came back without sign extension", addr));
        v = d[13:0];
    endtask

    function automatic logic [`FADS_ADDR_BITS-1:0] counter_addr(input int idx);
        case (idx)
            0:       return `FADS_ADDR_LOW_INT_CNT;
            1:       return `FADS_ADDR_HIGH_INT_CNT;
            2:       return `FADS_ADDR_SHORT_CNT;
            3:       return `FADS_ADDR_LONG_CNT;
            4:       return `FADS_ADDR_POS_CNT;
            5:       return `FADS_ADDR_NEG_CNT;
            default: return `FADS_ADDR_DROPLET_ID;
        endcase
    endfunction

    task automatic take_snapshot();
        logic [31:0] d;
        for (int i = 0; i < 7; i++) begin
            bus_read(counter_addr(i), d);
            snap[i] = d;
        end
    endtask

    // low, high, short, long, positive, negative, droplet id
    task automatic check_deltas(input count_t dl, input count_t dh, input count_t ds,
                                input count_t dg, input count_t dp, input count_t dn,
                                input count_t di);
        count_t      exp_d[7];
        logic [31:0] d;
        exp_d = '{dl, dh, ds, dg, dp, dn, di};
        for (int i = 0; i < 7; i++) begin
            bus_read(counter_addr(i), d);
            check_count(d, snap[i] + exp_d[i], $sformatf("counter at 0x%03h", counter_addr(i)));
            snap[i] = d;
        end
    endtask

    // random peak inside [lo, hi]
    function automatic adc_sample_t pick_peak(input int lo, input int hi);
        int span;
        int offs;
        span = hi - lo + 1;
        offs = int'({$random(seed)} % span);
        return adc_sample_t'(lo + offs);
    endfunction

    // flat-top droplet on a dark baseline
    task automatic send_droplet(input adc_sample_t peak, input int width);
        @(negedge adc_clk_i);
        adc_a_i = BASELINE;
        repeat (width) begin
            @(negedge adc_clk_i);
            adc_a_i = peak;
        end
        @(negedge adc_clk_i);
        adc_a_i = BASELINE;
        repeat (3) @(negedge adc_clk_i);
    endtask

    task automatic wait_trigger_rise();
        int waited;
        waited = 0;
        while (!sort_trig_o) begin
            if (waited == TRIG_TIMEOUT) abort_run("sort trigger never rose");
            @(negedge adc_clk_i);
            waited++;
        end
    endtask

    task automatic measure_pulse(output count_t len);
        len = 0;
        while (sort_trig_o) begin
            if (len == TRIG_TIMEOUT) abort_run("sort trigger stuck high");
            @(negedge adc_clk_i);
            len++;
        end
    endtask

    task automatic expect_no_trigger(input int cycles);
        repeat (cycles) begin
            @(negedge adc_clk_i);
            if (sort_trig_o) abort_run("sort trigger fired when no sort was due");
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] d;
        adc_sample_t s;
        read_sample(`FADS_ADDR_MIN_INT, s);
        check_sample(s, -14'sd250, "min_int");
        read_sample(`FADS_ADDR_LOW_INT, s);
        check_sample(s, -14'sd240, "low_int");
        read_sample(`FADS_ADDR_HIGH_INT, s);
        check_sample(s, 14'sd500, "high_int");
        bus_read(`FADS_ADDR_MIN_WIDTH, d);
        check_width(d, 32'd1, "min_width");
        bus_read(`FADS_ADDR_LOW_WIDTH, d);
        check_width(d, 32'd4, "low_width");
        bus_read(`FADS_ADDR_HIGH_WIDTH, d);
        check_width(d, 32'd1000, "high_width");
        bus_read(`FADS_ADDR_SORT_DELAY, d);
        check_count(d, 32'd31250, "sort_delay");
        bus_read(`FADS_ADDR_SORT_DUR, d);
        check_count(d, 32'd125000, "sort_duration");
        take_snapshot();
        for (int i = 0; i < 7; i++) check_count(snap[i], 32'd0, "counter after reset");
        // negative threshold round trip, then back to default
        bus_write(`FADS_ADDR_LOW_INT, -245);
        read_sample(`FADS_ADDR_LOW_INT, s);
        check_sample(s, -14'sd245, "written low_int");
        bus_write(`FADS_ADDR_LOW_INT, -240);
    endtask

    task automatic test_positive_droplet();
        logic [31:0] d;
        adc_sample_t s;
        adc_sample_t peak;
        peak = pick_peak(-240, 499);
        send_droplet(peak, 10);
        check_deltas(0, 0, 0, 0, 1, 0, 1);
        read_sample(`FADS_ADDR_LAST_PEAK, s);
        check_sample(s, peak, "last peak");
        bus_read(`FADS_ADDR_LAST_WIDTH, d);
        check_width(d, 32'd10, "last width");
        bus_read(`FADS_ADDR_CLASS, d);
        check_class(d[7:0], 8'h92);
    endtask

    task automatic test_negative_droplets();
        logic [31:0] d;
        // low intensity, positive width
        send_droplet(pick_peak(-250, -241), 10);
        check_deltas(1, 0, 0, 0, 0, 1, 1);
        bus_read(`FADS_ADDR_CLASS, d);
        check_class(d[7:0], 8'h11);
        // high intensity
        send_droplet(pick_peak(500, 8191), 10);
        check_deltas(0, 1, 0, 0, 0, 1, 1);
        bus_read(`FADS_ADDR_CLASS, d);
        check_class(d[7:0], 8'h14);
        // short
        send_droplet(pick_peak(-240, 499), 2);
        check_deltas(0, 0, 1, 0, 0, 1, 1);
        bus_read(`FADS_ADDR_CLASS, d);
        check_class(d[7:0], 8'h0A);
        // long
        send_droplet(pick_peak(-240, 499), 2000);
        check_deltas(0, 0, 0, 1, 0, 1, 1);
        bus_read(`FADS_ADDR_CLASS, d);
        check_class(d[7:0], 8'h22);
        bus_read(`FADS_ADDR_LAST_WIDTH, d);
        check_width(d, 32'd2000, "last width");
    endtask

    task automatic test_sort_trigger();
        count_t len;
        send_droplet(pick_peak(-240, 499), 10);
        wait_trigger_rise();
        measure_pulse(len);
        check_count(len, 32'd10, "trigger pulse length");
        // negative droplet, trigger must stay low
        send_droplet(pick_peak(-250, -241), 10);
        expect_no_trigger(100);
        take_snapshot();
    endtask

    task automatic test_noise_and_busy();
        count_t len;
        bus_write(`FADS_ADDR_MIN_WIDTH, 32'd3);
        take_snapshot();
        send_droplet(pick_peak(-240, 499), 2);
        check_deltas(0, 0, 0, 0, 0, 0, 0);
        // second positive droplet lands while the first pulse is active
        send_droplet(pick_peak(-240, 499), 10);
        wait_trigger_rise();
        send_droplet(pick_peak(-240, 499), 4);
        measure_pulse(len);
        // the 4-sample droplet took width + 5 cycles of the pulse
        check_count(len + 32'd9, 32'd10, "trigger pulse length");
        expect_no_trigger(100);
        check_deltas(0, 0, 0, 0, 2, 0, 2);
    endtask

    initial begin
        fads_reset  = 1'b1;
        adc_a_i     = BASELINE;
        sys_addr_i  = 32'd0;
        sys_wdata_i = 32'd0;
        sys_wen_i   = 1'b0;
        sys_ren_i   = 1'b0;
        repeat (8) @(negedge adc_clk_i);
        fads_reset = 1'b0;
        test_reset_values();
        // short sort timing for the rest of the run
        bus_write(`FADS_ADDR_SORT_DELAY, 32'd5);
        bus_write(`FADS_ADDR_SORT_DUR, 32'd10);
        test_positive_droplet();
        test_negative_droplets();
        test_sort_trigger();
        test_noise_and_busy();
        $display("test passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/fads_pkg.sv
src/droplet/window_classify.sv
src/droplet/droplet_measure.sv
src/droplet/droplet_eval.sv
src/sort_timer.sv
src/fads_regs.sv
src/fads_top.sv
testbench/tb_fads.sv

/* Makefile */
TOP = tb_fads

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
